// ==== design/soc_bus_pkg.sv ====
package soc_bus_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  localparam int ADDR_WIDTH     = 32;
  localparam int DATA_WIDTH     = 64;
  localparam int BE_WIDTH       = DATA_WIDTH / 8;
  // Word index into L2, above the byte bits
  localparam int WORD_IDX_WIDTH = 10;

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [BE_WIDTH-1:0]       be_t;
  typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;

  ////////////////////
  // Bus payloads
  ////////////////////

  // Single-beat access from the external master
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } bus_req_t;

  // One response per access
  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  // Routed access, offset is relative to the region base
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t offset;
    data_t wdata;
    be_t   be;
  } tgt_req_t;

  // Byte-lane merge shared by every writable target
  function automatic data_t apply_be(data_t old_word, data_t new_word, be_t be);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== design/soc_map_pkg.sv ====
package soc_map_pkg;

  ////////////////////
  // Target regions
  ////////////////////

  // NONE marks an access that hits no mapped window
  typedef enum logic [1:0] {
    L2MEM = 2'd0,
    CTRL  = 2'd1,
    DEBUG = 2'd2,
    NONE  = 2'd3
  } region_e;

  ////////////////////
  // Address map
  ////////////////////

  // On-chip L2, 64-bit words
  localparam logic [31:0] L2_BASE      = 32'h8000_0000;
  localparam int          L2_NUM_WORDS = 1024;
  localparam logic [31:0] L2_LENGTH    = 32'(L2_NUM_WORDS * 8);

  // Control register block
  localparam logic [31:0] CTRL_BASE   = 32'hD000_0000;
  localparam logic [31:0] CTRL_LENGTH = 32'h0000_1000;

  // Debug module window, served outside the chip
  localparam logic [31:0] DEBUG_BASE   = 32'h1A11_0000;
  localparam logic [31:0] DEBUG_LENGTH = 32'h0000_1000;

  ////////////////////
  // Control register offsets
  ////////////////////

  // Byte offsets from CTRL_BASE
  localparam logic [31:0] CTRL_EXIT_OFFSET   = 32'h0000_0000;
  localparam logic [31:0] CTRL_CNT_EN_OFFSET = 32'h0000_0008;

endpackage

// ==== design/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder import soc_bus_pkg::*; import soc_map_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  bus_req_t req_i,
  output tgt_req_t l2_req_o,
  output tgt_req_t ctrl_req_o,
  output tgt_req_t dm_req_o,
  output region_e  region_o,
  output logic     valid_o,
  output logic     we_o
);

  region_e  region_d;
  addr_t    offset_d;
  addr_t    l2_off;
  addr_t    ctrl_off;
  addr_t    dm_off;

  tgt_req_t req_q;
  region_e  region_q;

  ////////////////////
  // Region decode
  ////////////////////

  // Offset from each base, wraps below the base so one compare does
  assign l2_off   = req_i.addr - L2_BASE;
  assign ctrl_off = req_i.addr - CTRL_BASE;
  assign dm_off   = req_i.addr - DEBUG_BASE;

  always_comb begin
    region_d = NONE;
    offset_d = req_i.addr;
    if (l2_off < L2_LENGTH) begin
      region_d = L2MEM;
      offset_d = l2_off;
    end else if (ctrl_off < CTRL_LENGTH) begin
      region_d = CTRL;
      offset_d = ctrl_off;
    end else if (dm_off < DEBUG_LENGTH) begin
      region_d = DEBUG;
      offset_d = dm_off;
    end
  end

  ////////////////////
  // Request stage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q.valid <= 1'b0;
    end else begin
      req_q.valid <= req_i.valid;
    end
    req_q.we     <= req_i.we;
    req_q.offset <= offset_d;
    req_q.wdata  <= req_i.wdata;
    req_q.be     <= req_i.be;
    region_q     <= region_d;
  end

  // Strobe only the selected target
  always_comb begin
    l2_req_o         = req_q;
    l2_req_o.valid   = req_q.valid && (region_q == L2MEM);
    ctrl_req_o       = req_q;
    ctrl_req_o.valid = req_q.valid && (region_q == CTRL);
    dm_req_o         = req_q;
    dm_req_o.valid   = req_q.valid && (region_q == DEBUG);
  end

  // Access info for the response path
  assign region_o = region_q;
  assign valid_o  = req_q.valid;
  assign we_o     = req_q.we;

endmodule

// ==== design/l2_mem.sv ====
`timescale 1ns/1ps

module l2_mem import soc_bus_pkg::*; (
  input  logic     clk_i,
  input  tgt_req_t req_i,
  output data_t    rdata_o
);

  localparam int NUM_WORDS = 1 << WORD_IDX_WIDTH;

  data_t     mem [NUM_WORDS];
  data_t     rdata_q;
  word_idx_t word_idx;

  // Drop the byte bits of the offset
  assign word_idx = req_i.offset[WORD_IDX_WIDTH+$clog2(BE_WIDTH)-1:$clog2(BE_WIDTH)];

  ////////////////////
  // Storage
  ////////////////////

  // Byte-enable write
  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.we) begin
      mem[word_idx] <= apply_be(mem[word_idx], req_i.wdata, req_i.be);
    end
  end

  // One-cycle read, word held until the next read
  always_ff @(posedge clk_i) begin
    if (req_i.valid && !req_i.we) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== design/ctrl_regs.sv ====
`timescale 1ns/1ps

module ctrl_regs import soc_bus_pkg::*; import soc_map_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  tgt_req_t req_i,
  output data_t    exit_o,
  output data_t    hw_cnt_en_o,
  output data_t    rdata_o
);

  data_t exit_q;
  data_t cnt_en_q;
  data_t rdata_q;
  logic  sel_exit;
  logic  sel_cnt_en;

  // Offset decode
  assign sel_exit   = (req_i.offset == CTRL_EXIT_OFFSET);
  assign sel_cnt_en = (req_i.offset == CTRL_CNT_EN_OFFSET);

  ////////////////////
  // Register writes
  ////////////////////

  // Unknown offsets fall through untouched
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
    end else if (req_i.valid && req_i.we) begin
      if (sel_exit) begin
        exit_q <= apply_be(exit_q, req_i.wdata, req_i.be);
      end
      if (sel_cnt_en) begin
        cnt_en_q <= apply_be(cnt_en_q, req_i.wdata, req_i.be);
      end
    end
  end

  ////////////////////
  // Register reads
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i.valid && !req_i.we) begin
      if (sel_exit) begin
        rdata_q <= exit_q;
      end else if (sel_cnt_en) begin
        rdata_q <= cnt_en_q;
      end else begin
        // Hole in the block reads as zero
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o     = rdata_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

// ==== design/rsp_mux.sv ====
`timescale 1ns/1ps

module rsp_mux import soc_bus_pkg::*; import soc_map_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  region_e  region_i,
  input  logic     valid_i,
  input  logic     we_i,
  input  data_t    l2_rdata_i,
  input  data_t    ctrl_rdata_i,
  input  data_t    dm_rdata_i,
  output bus_rsp_t rsp_o
);

  region_e  region_q;
  logic     valid_q;
  logic     we_q;
  data_t    rdata_sel;
  bus_rsp_t rsp_d;
  bus_rsp_t rsp_q;

  ////////////////////
  // Access in flight
  ////////////////////

  // Lines up with the cycle the targets answer in
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
    region_q <= region_i;
    we_q     <= we_i;
  end

  ////////////////////
  // Merge
  ////////////////////

  always_comb begin
    case (region_q)
      L2MEM:   rdata_sel = l2_rdata_i;
      CTRL:    rdata_sel = ctrl_rdata_i;
      DEBUG:   rdata_sel = dm_rdata_i;
      default: rdata_sel = '0;
    endcase

    rsp_d.valid = valid_q;
    rsp_d.err   = (region_q == NONE);
    // Writes carry no data
    rsp_d.rdata = we_q ? '0 : rdata_sel;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q.valid <= 1'b0;
    end else begin
      rsp_q.valid <= rsp_d.valid;
    end
    rsp_q.err   <= rsp_d.err;
    rsp_q.rdata <= rsp_d.rdata;
  end

  assign rsp_o = rsp_q;

endmodule

// ==== design/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top import soc_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o,
  output data_t    exit_o,
  output data_t    hw_cnt_en_o,
  output tgt_req_t dm_req_o,
  input  data_t    dm_rdata_i
);

  tgt_req_t             l2_req;
  tgt_req_t             ctrl_req;
  soc_map_pkg::region_e region;
  logic                 dec_valid;
  logic                 dec_we;
  data_t                l2_rdata;
  data_t                ctrl_rdata;

  ////////////////////
  // Request routing
  ////////////////////

  addr_decoder u_addr_decoder (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .l2_req_o  (l2_req),
    .ctrl_req_o(ctrl_req),
    .dm_req_o  (dm_req_o),
    .region_o  (region),
    .valid_o   (dec_valid),
    .we_o      (dec_we)
  );

  ////////////////////
  // Targets
  ////////////////////

  l2_mem u_l2_mem (
    .clk_i  (clk_i),
    .req_i  (l2_req),
    .rdata_o(l2_rdata)
  );

  ctrl_regs u_ctrl_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (ctrl_req),
    .exit_o     (exit_o),
    .hw_cnt_en_o(hw_cnt_en_o),
    .rdata_o    (ctrl_rdata)
  );

  // Debug window answers through dm_rdata_i

  ////////////////////
  // Response
  ////////////////////

  rsp_mux u_rsp_mux (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .region_i    (region),
    .valid_i     (dec_valid),
    .we_i        (dec_we),
    .l2_rdata_i  (l2_rdata),
    .ctrl_rdata_i(ctrl_rdata),
    .dm_rdata_i  (dm_rdata_i),
    .rsp_o       (rsp_o)
  );

endmodule

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
  output logic clk_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

endmodule

// ==== sim/tb_soc_bus.sv ====
`timescale 1ns/1ps

module tb_soc_bus
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
();

  localparam int          MAX_TESTS  = 64;
  localparam int          TIMEOUT    = 10;
  // Request driven at edge e is sampled at e+1 and answered after e+3
  localparam int          LATENCY    = 3;
  localparam logic [63:0] DM_PATTERN = 64'hDB00_0000_0000_0000;

  logic     clk_i;
  logic     reset_i;
  bus_req_t req;
  bus_rsp_t rsp;
  data_t    exit_val;
  data_t    cnt_en;
  tgt_req_t dm_req;
  data_t    dm_rdata = '0;

  // Six words per access in file column order
  logic [63:0] vec_mem [0:6*MAX_TESTS-1];
  int          cyc = 0;
  int          errors = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  data_t       exit_model = '0;
  data_t       cnt_model = '0;

  int       issue_q[$];
  int       rsp_cyc_q[$];
  bus_rsp_t rsp_q[$];
  tgt_req_t dm_q[$];

  clk_gen u_clk_gen (
    .clk_o(clk_i)
  );

  soc_bus_top u_dut (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (req),
    .rsp_o      (rsp),
    .exit_o     (exit_val),
    .hw_cnt_en_o(cnt_en),
    .dm_req_o   (dm_req),
    .dm_rdata_i (dm_rdata)
  );

  ////////////////////
  // Debug module and monitors
  ////////////////////

  // Answers each read one cycle after its strobe
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (dm_req.valid && !dm_req.we) begin
      dm_rdata <= data_t'(dm_req.offset) ^ DM_PATTERN;
    end
  end

  // Sampled mid-cycle away from the clock edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (req.valid) begin
        issue_q.push_back(cyc);
      end
      if (rsp.valid) begin
        rsp_q.push_back(rsp);
        rsp_cyc_q.push_back(cyc);
      end
      if (dm_req.valid) begin
        dm_q.push_back(dm_req);
      end
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic region_e region_of(input addr_t a);
    if (a >= L2_BASE && a < L2_BASE + L2_LENGTH) begin
      return L2MEM;
    end else if (a >= CTRL_BASE && a < CTRL_BASE + CTRL_LENGTH) begin
      return CTRL;
    end else if (a >= DEBUG_BASE && a < DEBUG_BASE + DEBUG_LENGTH) begin
      return DEBUG;
    end
    return NONE;
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input be_t be);
    data_t res;
    for (int b = 0; b < 8; b++) begin
      res[8*b +: 8] = be[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return res;
  endfunction

  function automatic bus_req_t make_req(input int i);
    bus_req_t r;
    r.valid = 1'b1;
    r.we    = vec_mem[6*i][0];
    r.addr  = vec_mem[6*i+1][31:0];
    r.wdata = vec_mem[6*i+2];
    r.be    = vec_mem[6*i+3][7:0];
    return r;
  endfunction

  task automatic check_value(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_entry(input int i);
    logic [63:0] op;
    addr_t       addr;
    bus_rsp_t    r;
    tgt_req_t    d;
    int          err_before;
    int          t_req;
    int          t_rsp;
    err_before = errors;
    op         = vec_mem[6*i];
    addr       = vec_mem[6*i+1][31:0];
    r          = rsp_q.pop_front();
    t_rsp      = rsp_cyc_q.pop_front();
    t_req      = issue_q.pop_front();
    if (t_rsp - t_req != LATENCY) begin
      $display("Test %0d was issued at cycle %0d but answered at cycle %0d", i, t_req, t_rsp);
      errors++;
    end
    check_value("rsp_o.err", vec_mem[6*i+5], data_t'(r.err));
    check_value("rsp_o.rdata", vec_mem[6*i+4], r.rdata);
    if (region_of(addr) == DEBUG) begin
      if (dm_q.size() == 0) begin
        $display("Test %0d never reached the debug module", i);
        errors++;
      end else begin
        d = dm_q.pop_front();
        check_value("dm_req_o.offset", data_t'(addr - DEBUG_BASE), data_t'(d.offset));
        check_value("dm_req_o.we", data_t'(op[0]), data_t'(d.we));
        if (op[0]) begin
          check_value("dm_req_o.wdata", vec_mem[6*i+2], d.wdata);
          check_value("dm_req_o.be", vec_mem[6*i+3], data_t'(d.be));
        end
      end
    end
    // Expected control register state
    if (op[0] && region_of(addr) == CTRL) begin
      if (addr - CTRL_BASE == CTRL_EXIT_OFFSET) begin
        exit_model = merge_bytes(exit_model, vec_mem[6*i+2], vec_mem[6*i+3][7:0]);
      end else if (addr - CTRL_BASE == CTRL_CNT_EN_OFFSET) begin
        cnt_model = merge_bytes(cnt_model, vec_mem[6*i+2], vec_mem[6*i+3][7:0]);
      end
    end
    if (errors == err_before) begin
      pass_cnt++;
      $display("Test %0d %s 0x%h ok", i, op[0] ? "write" : "read", addr);
    end else begin
      fail_cnt++;
      $display("Test %0d %s 0x%h failed", i, op[0] ? "write" : "read", addr);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int   n;
    int   first;
    int   last;
    int   waited;
    logic timed_out;
    req       = '0;
    reset_i   = 1'b1;
    timed_out = 1'b0;
    $readmemh("sim/soc_bus_tests.txt", vec_mem);
    n = 0;
    while (n < MAX_TESTS && vec_mem[6*n] != 64'hF) begin
      n++;
    end

    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("exit_o", '0, exit_val);
    check_value("hw_cnt_en_o", '0, cnt_en);
    check_value("rsp_o.valid", '0, data_t'(rsp.valid));
    check_value("dm_req_o.valid", '0, data_t'(dm_req.valid));

    first = 0;
    while (first < n && !timed_out) begin
      // Lines with op bit 1 follow the line above on the next cycle
      last = first;
      while (last + 1 < n && vec_mem[6*(last+1)][1]) begin
        last++;
      end
      for (int i = first; i <= last; i++) begin
        @(posedge clk_i);
        req <= make_req(i);
      end
      @(posedge clk_i);
      req.valid <= 1'b0;

      waited = 0;
      while (rsp_q.size() < last - first + 1 && waited < TIMEOUT) begin
        @(posedge clk_i);
        waited++;
      end
      if (rsp_q.size() < last - first + 1) begin
        $display("Timeout after %0d cycles waiting for the response to test %0d",
                 TIMEOUT, first + rsp_q.size());
        errors++;
        timed_out = 1'b1;
      end else begin
        for (int i = first; i <= last; i++) begin
          check_entry(i);
        end
        @(negedge clk_i);
        check_value("exit_o", exit_model, exit_val);
        check_value("hw_cnt_en_o", cnt_model, cnt_en);
        // Let the monitor finish this half cycle first
        @(posedge clk_i);
        if (dm_q.size() != 0 || rsp_q.size() != 0) begin
          $display("Unexpected debug strobe or response after test %0d", last);
          errors++;
        end
        dm_q.delete();
        rsp_q.delete();
        rsp_cyc_q.delete();
      end
      first = last + 1;
    end

    $display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/soc_bus_tests.txt ====
// op addr wdata be rdata err, all hex; op bit 0 is write, bit 1 issues on the next cycle
// op f ends the list
1 80000000 1122334455667788 ff 0000000000000000 0
0 80000000 0 00 1122334455667788 0
1 80000000 cafef00ddeadbeef f0 0 0
0 80000000 0 00 cafef00d55667788 0
1 80000008 0123456789abcdef ff 0 0
1 80000008 ffffffffffffffff 81 0 0
0 80000008 0 00 ff23456789abcdff 0
1 80001ff8 a5a5a5a5a5a5a5a5 ff 0 0
0 80001ff8 0 00 a5a5a5a5a5a5a5a5 0
0 d0000000 0 00 0 0
1 d0000000 0000000000000001 01 0 0
0 d0000000 0 00 0000000000000001 0
1 d0000008 000000000000ffff 03 0 0
1 d0000008 123456789abcdef0 f0 0 0
0 d0000008 0 00 123456780000ffff 0
1 d0000010 deadbeefdeadbeef ff 0 0
0 d0000010 0 00 0 0
0 1a110040 0 00 db00000000000040 0
1 1a110100 0123456789abcdef 3c 0 0
0 1a110ff8 0 00 db00000000000ff8 0
0 00000000 0 00 0 1
1 80002000 ffffffffffffffff ff 0 1
1 d0001000 ffffffffffffffff ff 0 1
0 80000000 0 00 cafef00d55667788 0
1 80000010 1111111111111111 ff 0 0
3 80000018 2222222222222222 ff 0 0
2 80000010 0 00 1111111111111111 0
2 80000018 0 00 2222222222222222 0
2 d0000008 0 00 123456780000ffff 0
2 1a110020 0 00 db00000000000020 0
2 00001000 0 00 0 1
3 d0000000 0 01 0 0
2 d0000000 0 00 0 0
f 0 0 0 0 0

// ==== tb.f ====
design/soc_bus_pkg.sv
design/soc_map_pkg.sv
design/addr_decoder.sv
design/l2_mem.sv
design/ctrl_regs.sv
design/rsp_mux.sv
design/soc_bus_top.sv
sim/clk_gen.sv
sim/tb_soc_bus.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_soc_bus
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
PASS_STR = STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
